// ==== logic/qspi_csr_pkg.sv ====
/*
 * QSPI CSR shared definitions
 * Register offsets, write masks, reset values and the packed
 * structs passed between APB decode, register file and readback.
 */
package qspi_csr_pkg;

  localparam int addr_w    = 12;
  localparam int data_w    = 32;
  localparam int strb_w    = 4;
  localparam int clk_div_w = 4;

  // ----------------------------------------------------------
  // Register map
  // ----------------------------------------------------------
  localparam logic [addr_w-1:0] id_addr       = 12'h000;
  localparam logic [addr_w-1:0] ctrl_addr     = 12'h004;
  localparam logic [addr_w-1:0] status_addr   = 12'h008;
  localparam logic [addr_w-1:0] int_en_addr   = 12'h00C;
  localparam logic [addr_w-1:0] int_stat_addr = 12'h010;
  localparam logic [addr_w-1:0] clk_div_addr  = 12'h014;
  localparam logic [addr_w-1:0] cmd_cfg_addr  = 12'h024;
  localparam logic [addr_w-1:0] cmd_op_addr   = 12'h028;
  localparam logic [addr_w-1:0] cmd_addr_addr = 12'h02C;
  localparam logic [addr_w-1:0] cmd_len_addr  = 12'h030;

  localparam logic [data_w-1:0] id_value = 32'h1A00_1081;

  // Writable bits per register
  localparam logic [data_w-1:0] ctrl_wmask    = 32'h0000_023F;
  localparam logic [data_w-1:0] clk_div_wmask = 32'h0000_000F;
  localparam logic [data_w-1:0] cmd_cfg_wmask = 32'h0000_3FFF;
  localparam logic [data_w-1:0] cmd_op_wmask  = 32'h0000_FFFF;

  // CTRL write-one-to-start bit is never stored
  localparam int ctrl_trig_bit = 8;

  // Interrupt sources shared by INT_EN and INT_STAT
  localparam int int_src_n   = 2;
  localparam int int_done_bit = 0;
  localparam int int_err_bit  = 1;
  localparam logic [data_w-1:0] int_wmask = (32'h1 << int_src_n) - 32'h1;

  typedef enum logic [3:0] {
    reg_id, reg_ctrl, reg_status, reg_int_en, reg_int_stat,
    reg_clk_div, reg_cmd_cfg, reg_cmd_op, reg_cmd_addr, reg_cmd_len,
    reg_none
  } reg_idx_e;

  // One decoded APB access
  typedef struct packed {
    logic              wr;
    logic              rd;
    reg_idx_e          idx;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] strb;
  } reg_access_t;

  typedef struct packed {
    logic enable;
    logic quad_en;
    logic cpol;
    logic cpha;
    logic lsb_first;
    logic hold_en;
  } ctrl_t;

  // Command descriptor toward the command engine
  typedef struct packed {
    logic [1:0]  cmd_lanes;
    logic [1:0]  addr_lanes;
    logic [1:0]  data_lanes;
    logic [1:0]  addr_bytes;
    logic [3:0]  dummy_cycles;
    logic        is_write;
    logic        mode_en;
    logic [7:0]  opcode;
    logic [7:0]  mode_bits;
    logic [31:0] cmd_addr;
    logic [31:0] cmd_len;
  } cmd_desc_t;

  // Stored register words
  typedef struct packed {
    logic [data_w-1:0] ctrl;
    logic [data_w-1:0] int_en;
    logic [data_w-1:0] int_stat;
    logic [data_w-1:0] clk_div;
    logic [data_w-1:0] cmd_cfg;
    logic [data_w-1:0] cmd_op;
    logic [data_w-1:0] cmd_addr;
    logic [data_w-1:0] cmd_len;
    logic              cmd_done;
  } csr_regs_t;

  localparam csr_regs_t regs_rst = '0;

endpackage

// ==== logic/apb_decode.sv ====
/*
 * APB decode
 * Zero wait-state access decode that maps the address onto a register
 * index, flags illegal writes with PSLVERR and issues the write and
 * read strobes toward the register file.
 */
`timescale 1ns/1ps

module apb_decode (
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [qspi_csr_pkg::addr_w-1:0]     paddr_i,
  input  logic [qspi_csr_pkg::data_w-1:0]     pwdata_i,
  input  logic [qspi_csr_pkg::strb_w-1:0]     pstrb_i,
  input  logic                                busy_i,
  output qspi_csr_pkg::reg_access_t           access_o,
  output logic                                pslverr_o
);

  qspi_csr_pkg::reg_idx_e idx;
  logic                   wr_phase;
  logic                   rd_phase;
  logic                   trig_busy;
  logic                   wr_err;

  assign wr_phase = psel_i & penable_i & pwrite_i;
  assign rd_phase = psel_i & penable_i & ~pwrite_i;

  always_comb begin
    unique case (paddr_i)
      qspi_csr_pkg::id_addr:       idx = qspi_csr_pkg::reg_id;
      qspi_csr_pkg::ctrl_addr:     idx = qspi_csr_pkg::reg_ctrl;
      qspi_csr_pkg::status_addr:   idx = qspi_csr_pkg::reg_status;
      qspi_csr_pkg::int_en_addr:   idx = qspi_csr_pkg::reg_int_en;
      qspi_csr_pkg::int_stat_addr: idx = qspi_csr_pkg::reg_int_stat;
      qspi_csr_pkg::clk_div_addr:  idx = qspi_csr_pkg::reg_clk_div;
      qspi_csr_pkg::cmd_cfg_addr:  idx = qspi_csr_pkg::reg_cmd_cfg;
      qspi_csr_pkg::cmd_op_addr:   idx = qspi_csr_pkg::reg_cmd_op;
      qspi_csr_pkg::cmd_addr_addr: idx = qspi_csr_pkg::reg_cmd_addr;
      qspi_csr_pkg::cmd_len_addr:  idx = qspi_csr_pkg::reg_cmd_len;
      default:                     idx = qspi_csr_pkg::reg_none;
    endcase
  end

  // ----------------------------------------------------------
  // Error response
  // ----------------------------------------------------------
  // Trigger while the engine is busy rejects the whole CTRL write
  assign trig_busy = (idx == qspi_csr_pkg::reg_ctrl) & pstrb_i[1] &
                     pwdata_i[qspi_csr_pkg::ctrl_trig_bit] & busy_i;

  // STATUS accepts writes for its clear bit and ID takes none
  assign wr_err = (idx == qspi_csr_pkg::reg_none) |
                  (idx == qspi_csr_pkg::reg_id) | trig_busy;

  assign pslverr_o = wr_phase & wr_err;

  always_comb begin
    access_o.wr    = wr_phase & ~wr_err;
    access_o.rd    = rd_phase & (idx != qspi_csr_pkg::reg_none);
    access_o.idx   = idx;
    access_o.wdata = pwdata_i;
    access_o.strb  = pstrb_i;
  end

endmodule

// ==== logic/csr_regfile.sv ====
/*
 * QSPI CSR register file
 * Strobed, masked register writes, write-one-to-clear handling,
 * interrupt latching with a level irq, and the command start flag.
 */
`timescale 1ns/1ps

module csr_regfile (
  input  logic                                pclk,
  input  logic                                presetn,
  input  qspi_csr_pkg::reg_access_t           access_i,
  input  logic                                cmd_trigger_clr_i,
  input  logic                                cmd_done_set_i,
  input  logic                                err_set_i,
  output qspi_csr_pkg::csr_regs_t             regs_o,
  output qspi_csr_pkg::ctrl_t                 ctrl_o,
  output qspi_csr_pkg::cmd_desc_t             cmd_o,
  output logic [qspi_csr_pkg::clk_div_w-1:0]  clk_div_o,
  output logic                                cmd_start_o,
  output logic                                irq_o
);

  qspi_csr_pkg::csr_regs_t         regs_q;
  qspi_csr_pkg::csr_regs_t         regs_d;
  logic [qspi_csr_pkg::data_w-1:0] byte_en;
  logic [qspi_csr_pkg::data_w-1:0] ones_wr;
  logic [qspi_csr_pkg::data_w-1:0] ctrl_raw;
  logic                            trig;
  logic                            start_q;

  // Byte strobes expanded to a bit mask
  always_comb begin
    for (int i = 0; i < qspi_csr_pkg::strb_w; i++) begin
      byte_en[8*i +: 8] = {8{access_i.strb[i]}};
    end
  end

  // Bits written as one in enabled bytes for the W1C registers
  assign ones_wr = access_i.wdata & byte_en;

  function automatic logic [qspi_csr_pkg::data_w-1:0] merge(
    input logic [qspi_csr_pkg::data_w-1:0] cur,
    input logic [qspi_csr_pkg::data_w-1:0] wmask
  );
    merge = ((access_i.wdata & byte_en) | (cur & ~byte_en)) & wmask;
  endfunction

  // ----------------------------------------------------------
  // Command trigger
  // ----------------------------------------------------------
  // Enable is taken as it stands after this write, so one write can
  // enable and start together
  assign ctrl_raw = (access_i.wdata & byte_en) | (regs_q.ctrl & ~byte_en);
  assign trig     = access_i.wr & (access_i.idx == qspi_csr_pkg::reg_ctrl) &
                    ctrl_raw[qspi_csr_pkg::ctrl_trig_bit] & ctrl_raw[0];

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      start_q <= 1'b0;
    end else if (cmd_trigger_clr_i) begin
      start_q <= 1'b0;
    end else if (trig) begin
      start_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Register update
  // ----------------------------------------------------------
  always_comb begin
    regs_d = regs_q;
    if (access_i.wr) begin
      unique case (access_i.idx)
        qspi_csr_pkg::reg_ctrl:
          regs_d.ctrl = merge(regs_q.ctrl, qspi_csr_pkg::ctrl_wmask);
        qspi_csr_pkg::reg_status:
          if (ones_wr[0]) regs_d.cmd_done = 1'b0;
        qspi_csr_pkg::reg_int_en:
          regs_d.int_en = merge(regs_q.int_en, qspi_csr_pkg::int_wmask);
        qspi_csr_pkg::reg_int_stat:
          regs_d.int_stat = regs_q.int_stat & ~ones_wr;
        qspi_csr_pkg::reg_clk_div:
          regs_d.clk_div = merge(regs_q.clk_div, qspi_csr_pkg::clk_div_wmask);
        qspi_csr_pkg::reg_cmd_cfg:
          regs_d.cmd_cfg = merge(regs_q.cmd_cfg, qspi_csr_pkg::cmd_cfg_wmask);
        qspi_csr_pkg::reg_cmd_op:
          regs_d.cmd_op = merge(regs_q.cmd_op, qspi_csr_pkg::cmd_op_wmask);
        qspi_csr_pkg::reg_cmd_addr:
          regs_d.cmd_addr = merge(regs_q.cmd_addr, '1);
        qspi_csr_pkg::reg_cmd_len:
          regs_d.cmd_len = merge(regs_q.cmd_len, '1);
        default: ;
      endcase
    end
    // A new event wins over a clear in the same cycle
    if (cmd_done_set_i) begin
      regs_d.int_stat[qspi_csr_pkg::int_done_bit] = 1'b1;
      regs_d.cmd_done = 1'b1;
    end
    if (err_set_i) begin
      regs_d.int_stat[qspi_csr_pkg::int_err_bit] = 1'b1;
    end
  end

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      regs_q <= qspi_csr_pkg::regs_rst;
    end else begin
      regs_q <= regs_d;
    end
  end

  // ----------------------------------------------------------
  // Field outputs
  // ----------------------------------------------------------
  // CTRL bit 1 has no function here and only reads back
  always_comb begin
    ctrl_o.enable    = regs_q.ctrl[0];
    ctrl_o.quad_en   = regs_q.ctrl[2];
    ctrl_o.cpol      = regs_q.ctrl[3];
    ctrl_o.cpha      = regs_q.ctrl[4];
    ctrl_o.lsb_first = regs_q.ctrl[5];
    ctrl_o.hold_en   = regs_q.ctrl[9];

    cmd_o.cmd_lanes    = regs_q.cmd_cfg[1:0];
    cmd_o.addr_lanes   = regs_q.cmd_cfg[3:2];
    cmd_o.data_lanes   = regs_q.cmd_cfg[5:4];
    cmd_o.addr_bytes   = regs_q.cmd_cfg[7:6];
    cmd_o.dummy_cycles = regs_q.cmd_cfg[11:8];
    cmd_o.is_write     = regs_q.cmd_cfg[12];
    cmd_o.mode_en      = regs_q.cmd_cfg[13];
    cmd_o.opcode       = regs_q.cmd_op[7:0];
    cmd_o.mode_bits    = regs_q.cmd_op[15:8];
    cmd_o.cmd_addr     = regs_q.cmd_addr;
    cmd_o.cmd_len      = regs_q.cmd_len;
  end

  assign clk_div_o   = regs_q.clk_div[qspi_csr_pkg::clk_div_w-1:0];
  assign cmd_start_o = start_q;
  assign irq_o       = |(regs_q.int_en[qspi_csr_pkg::int_src_n-1:0] &
                         regs_q.int_stat[qspi_csr_pkg::int_src_n-1:0]);
  assign regs_o      = regs_q;

endmodule

// ==== logic/csr_readback.sv ====
/*
 * QSPI CSR readback
 * Read data multiplexer over the stored registers, the fixed ID
 * word and the live STATUS view. Zero outside a read access.
 */
`timescale 1ns/1ps

module csr_readback (
  input  qspi_csr_pkg::reg_access_t        access_i,
  input  qspi_csr_pkg::csr_regs_t          regs_i,
  input  logic                             busy_i,
  output logic [qspi_csr_pkg::data_w-1:0]  prdata_o
);

  logic [qspi_csr_pkg::data_w-1:0] status_word;

  // Bit 0 latched done, bit 1 live busy
  assign status_word = {30'd0, busy_i, regs_i.cmd_done};

  always_comb begin
    prdata_o = '0;
    if (access_i.rd) begin
      unique case (access_i.idx)
        qspi_csr_pkg::reg_id:       prdata_o = qspi_csr_pkg::id_value;
        qspi_csr_pkg::reg_ctrl:     prdata_o = regs_i.ctrl;
        qspi_csr_pkg::reg_status:   prdata_o = status_word;
        qspi_csr_pkg::reg_int_en:   prdata_o = regs_i.int_en;
        qspi_csr_pkg::reg_int_stat: prdata_o = regs_i.int_stat;
        qspi_csr_pkg::reg_clk_div:  prdata_o = regs_i.clk_div;
        qspi_csr_pkg::reg_cmd_cfg:  prdata_o = regs_i.cmd_cfg;
        qspi_csr_pkg::reg_cmd_op:   prdata_o = regs_i.cmd_op;
        qspi_csr_pkg::reg_cmd_addr: prdata_o = regs_i.cmd_addr;
        qspi_csr_pkg::reg_cmd_len:  prdata_o = regs_i.cmd_len;
        default:                    prdata_o = '0;
      endcase
    end
  end

endmodule

// ==== logic/qspi_csr_top.sv ====
/*
 * QSPI CSR top
 * APB3/4 slave with zero wait states holding the command-mode
 * control and status registers of the QSPI controller.
 */
`timescale 1ns/1ps

module qspi_csr_top (
  input  logic                                pclk,
  input  logic                                presetn,
  // APB
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [qspi_csr_pkg::addr_w-1:0]     paddr_i,
  input  logic [qspi_csr_pkg::data_w-1:0]     pwdata_i,
  input  logic [qspi_csr_pkg::strb_w-1:0]     pstrb_i,
  output logic [qspi_csr_pkg::data_w-1:0]     prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  // Controller side
  input  logic                                busy_i,
  input  logic                                cmd_trigger_clr_i,
  input  logic                                cmd_done_set_i,
  input  logic                                err_set_i,
  output qspi_csr_pkg::ctrl_t                 ctrl_o,
  output qspi_csr_pkg::cmd_desc_t             cmd_o,
  output logic [qspi_csr_pkg::clk_div_w-1:0]  clk_div_o,
  output logic                                cmd_start_o,
  output logic                                irq_o
);

  qspi_csr_pkg::reg_access_t access;
  qspi_csr_pkg::csr_regs_t   regs;

  // Every access completes in its access phase
  assign pready_o = 1'b1;

  apb_decode decode_i (
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .busy_i    (busy_i),
    .access_o  (access),
    .pslverr_o (pslverr_o)
  );

  csr_regfile regfile_i (
    .pclk              (pclk),
    .presetn           (presetn),
    .access_i          (access),
    .cmd_trigger_clr_i (cmd_trigger_clr_i),
    .cmd_done_set_i    (cmd_done_set_i),
    .err_set_i         (err_set_i),
    .regs_o            (regs),
    .ctrl_o            (ctrl_o),
    .cmd_o             (cmd_o),
    .clk_div_o         (clk_div_o),
    .cmd_start_o       (cmd_start_o),
    .irq_o             (irq_o)
  );

  csr_readback readback_i (
    .access_i (access),
    .regs_i   (regs),
    .busy_i   (busy_i),
    .prdata_o (prdata_o)
  );

endmodule

// ==== tb/csr_model.svh ====
/*
 * QSPI CSR reference model
 * Writable bits, strobe merge, write-one-to-clear rules and the
 * expected PSLVERR of an APB write.
 */
`ifndef csr_model_svh
`define csr_model_svh

// Bits a plain write can change
function automatic logic [31:0] wmask_of(input logic [11:0] addr);
  case (addr)
    qspi_csr_pkg::ctrl_addr:     return qspi_csr_pkg::ctrl_wmask;
    qspi_csr_pkg::int_en_addr:   return 32'h0000_0003;
    qspi_csr_pkg::clk_div_addr:  return qspi_csr_pkg::clk_div_wmask;
    qspi_csr_pkg::cmd_cfg_addr:  return qspi_csr_pkg::cmd_cfg_wmask;
    qspi_csr_pkg::cmd_op_addr:   return qspi_csr_pkg::cmd_op_wmask;
    qspi_csr_pkg::cmd_addr_addr: return 32'hFFFF_FFFF;
    qspi_csr_pkg::cmd_len_addr:  return 32'hFFFF_FFFF;
    default:                     return 32'h0000_0000;
  endcase
endfunction

// Stored word after an accepted write
function automatic logic [31:0] exp_write(input logic [11:0] addr, input logic [31:0] old,
                                          input logic [31:0] wdata, input logic [3:0] strb);
  logic [31:0] bytes;
  bytes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  // W1C words clear only the ones written in enabled bytes
  if (addr == qspi_csr_pkg::int_stat_addr) return old & ~(wdata & bytes);
  if (addr == qspi_csr_pkg::status_addr) return old & ~(wdata & bytes & 32'h1);
  return ((wdata & bytes) | (old & ~bytes)) & wmask_of(addr);
endfunction

function automatic logic exp_pslverr(input logic [11:0] addr, input logic [31:0] wdata,
                                     input logic [3:0] strb, input logic busy);
  logic mapped;
  mapped = (addr <= 12'h030) && (addr[1:0] == 2'b00) &&
           (addr != 12'h018) && (addr != 12'h01C) && (addr != 12'h020);
  if (!mapped || addr == qspi_csr_pkg::id_addr) return 1'b1;
  return (addr == qspi_csr_pkg::ctrl_addr) && strb[1] && wdata[8] && busy;
endfunction

`endif

// ==== tb/qspi_csr_tb.sv ====
/*
 * QSPI CSR testbench
 * Runs the APB slave through reset values, strobed and masked
 * writes, error responses, the command trigger and interrupts, and
 * compares each response with a register model.
 */
`timescale 1ns/1ps

module qspi_csr_tb;

  `include "csr_model.svh"

  localparam int half_period = 20;
  // The tests take about 600 cycles
  localparam int max_cycles = 4000;

  logic                    pclk;
  logic                    presetn;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [11:0]             paddr;
  logic [31:0]             pwdata;
  logic [3:0]              pstrb;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    busy;
  logic                    trig_clr;
  logic                    done_set;
  logic                    err_set;
  qspi_csr_pkg::ctrl_t     ctrl;
  qspi_csr_pkg::cmd_desc_t cmd;
  logic [3:0]              clk_div;
  logic                    cmd_start;
  logic                    irq;

  // Expected register words indexed by address / 4
  logic [31:0] model [0:12];
  int unsigned wr_idx [7] = '{1, 3, 5, 9, 10, 11, 12};
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;

  qspi_csr_top dut_i (
    .pclk              (pclk),
    .presetn           (presetn),
    .psel_i            (psel),
    .penable_i         (penable),
    .pwrite_i          (pwrite),
    .paddr_i           (paddr),
    .pwdata_i          (pwdata),
    .pstrb_i           (pstrb),
    .prdata_o          (prdata),
    .pready_o          (pready),
    .pslverr_o         (pslverr),
    .busy_i            (busy),
    .cmd_trigger_clr_i (trig_clr),
    .cmd_done_set_i    (done_set),
    .err_set_i         (err_set),
    .ctrl_o            (ctrl),
    .cmd_o             (cmd),
    .clk_div_o         (clk_div),
    .cmd_start_o       (cmd_start),
    .irq_o             (irq)
  );

  initial begin
    pclk = 1'b0;
    forever #half_period pclk = ~pclk;
  end

  always @(posedge pclk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Checks and APB driver
  // ----------------------------------------------------------
  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic err);
    @(negedge pclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(negedge pclk);
    penable = 1'b1;
    // Sample mid access phase away from both edges
    #(half_period / 2);
    err = pslverr;
    check("pready_o", pready, 1'b1);
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge pclk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge pclk);
    penable = 1'b1;
    #(half_period / 2);
    data = prdata;
    err  = pslverr;
    check("pready_o", pready, 1'b1);
    @(negedge pclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Write, check the response and follow it in the model
  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic err;
    logic exp_err;
    exp_err = exp_pslverr(addr, data, strb, busy);
    apb_write(addr, data, strb, err);
    check("pslverr_o", err, exp_err);
    if (!exp_err) begin
      model[addr >> 2] = exp_write(addr, model[addr >> 2], data, strb);
    end
  endtask

  // Reads the whole window including the unmapped holes
  task automatic check_map();
    logic [31:0] rd;
    logic        err;
    for (int a = 0; a <= 12; a++) begin
      apb_read(12'(a * 4), rd, err);
      check($sformatf("prdata_o @%03h", a * 4), rd, model[a]);
      check("pslverr_o on read", err, 1'b0);
    end
  endtask

  task automatic check_outputs();
    logic [31:0] c;
    logic [31:0] cfg;
    logic [31:0] op;
    c   = model[1];
    cfg = model[9];
    op  = model[10];
    check("ctrl_o", ctrl, {c[0], c[2], c[3], c[4], c[5], c[9]});
    check("cmd_o", cmd, {cfg[1:0], cfg[3:2], cfg[5:4], cfg[7:6], cfg[11:8], cfg[12],
                         cfg[13], op[7:0], op[15:8], model[11], model[12]});
    check("clk_div_o", clk_div, model[5][3:0]);
    check("irq_o", irq, |(model[3][1:0] & model[4][1:0]));
  endtask

  task automatic pulse_event(input logic done, input logic err);
    @(negedge pclk);
    done_set = done;
    err_set  = err;
    @(negedge pclk);
    done_set = 1'b0;
    err_set  = 1'b0;
    model[4] = model[4] | {30'd0, err, done};
    model[2] = model[2] | {31'd0, done};
  endtask

  task automatic end_test(input string name);
    $display("test %-10s %s, %0d errors", name,
             (errors == test_errors) ? "ok" : "failed", errors - test_errors);
    test_errors = errors;
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic        err;
    int unsigned sel;
    void'($urandom(32'he9ab0009));
    presetn  = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    pstrb    = '0;
    busy     = 1'b0;
    trig_clr = 1'b0;
    done_set = 1'b0;
    err_set  = 1'b0;
    for (int i = 0; i <= 12; i++) model[i] = 32'h0;
    model[0] = qspi_csr_pkg::id_value;
    repeat (10) @(negedge pclk);
    presetn = 1'b1;

    check_map();
    check("cmd_start_o", cmd_start, 1'b0);
    check_outputs();
    end_test("reset");

    repeat (40) begin
      sel = $urandom_range(6);
      write_reg(12'(wr_idx[sel] * 4), $urandom, 4'($urandom));
      apb_read(12'(wr_idx[sel] * 4), rd, err);
      check("prdata_o", rd, model[wr_idx[sel]]);
      check_outputs();
    end
    // Random CTRL data may have started a command
    @(negedge pclk);
    trig_clr = 1'b1;
    @(negedge pclk);
    trig_clr = 1'b0;
    check_map();
    end_test("masked");

    write_reg(12'h018, $urandom, 4'hF);
    write_reg(qspi_csr_pkg::id_addr, $urandom, 4'hF);
    busy = 1'b1;
    write_reg(qspi_csr_pkg::ctrl_addr, 32'h0000_0101, 4'h3);
    apb_read(qspi_csr_pkg::status_addr, rd, err);
    check("prdata_o STATUS busy", rd, model[2] | 32'h2);
    busy = 1'b0;
    check("cmd_start_o", cmd_start, 1'b0);
    apb_read(12'h100, rd, err);
    check("prdata_o @100", rd, 32'h0);
    check("pslverr_o on read", err, 1'b0);
    check_map();
    end_test("errors");

    check("cmd_start_o", cmd_start, 1'b0);
    write_reg(qspi_csr_pkg::ctrl_addr, 32'h0000_0101, 4'h3);
    check("cmd_start_o", cmd_start, 1'b1);
    repeat (3) @(negedge pclk);
    trig_clr = 1'b1;
    check("cmd_start_o", cmd_start, 1'b1);
    @(negedge pclk);
    check("cmd_start_o", cmd_start, 1'b0);
    // Clear held high wins over a new trigger
    write_reg(qspi_csr_pkg::ctrl_addr, 32'h0000_0101, 4'h3);
    check("cmd_start_o", cmd_start, 1'b0);
    trig_clr = 1'b0;
    apb_read(qspi_csr_pkg::ctrl_addr, rd, err);
    check("CTRL bit 8", rd[8], 1'b0);
    check("prdata_o CTRL", rd, model[1]);
    write_reg(qspi_csr_pkg::ctrl_addr, 32'h0000_0100, 4'h3);
    repeat (4) begin
      @(negedge pclk);
      check("cmd_start_o", cmd_start, 1'b0);
    end
    end_test("trigger");

    write_reg(qspi_csr_pkg::int_en_addr, 32'h1, 4'h1);
    pulse_event(1'b1, 1'b0);
    check_outputs();
    pulse_event(1'b0, 1'b1);
    check_outputs();
    check_map();
    write_reg(qspi_csr_pkg::int_en_addr, 32'h2, 4'h1);
    check_outputs();
    write_reg(qspi_csr_pkg::int_stat_addr, 32'h2, 4'h1);
    check_outputs();
    write_reg(qspi_csr_pkg::int_stat_addr, 32'h1, 4'h0);
    write_reg(qspi_csr_pkg::status_addr, 32'h2, 4'h1);
    check_map();
    write_reg(qspi_csr_pkg::status_addr, 32'h1, 4'h1);
    write_reg(qspi_csr_pkg::int_stat_addr, 32'h1, 4'h1);
    check_map();
    check_outputs();
    end_test("interrupt");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+tb
logic/qspi_csr_pkg.sv
logic/apb_decode.sv
logic/csr_regfile.sv
logic/csr_readback.sv
logic/qspi_csr_top.sv
tb/qspi_csr_tb.sv

// ==== Bender.yml ====
package:
  name: qspi_csr

sources:
  - logic/qspi_csr_pkg.sv
  - logic/apb_decode.sv
  - logic/csr_regfile.sv
  - logic/csr_readback.sv
  - logic/qspi_csr_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/qspi_csr_tb.sv
